/* common/regbank_config.svh */
`ifndef REGBANK_CONFIG_SVH
`define REGBANK_CONFIG_SVH

// size of the control register bank in bytes
`define REGBANK_N_BYTES 32

// wishbone side
`define WB_ADDR_W 8   // byte address
`define WB_DATA_W 32
`define WB_SEL_W  4   // one select per byte lane

// register file word address, log2(32 bytes / 4 lanes)
`define RF_WADDR_W 3

`endif

/* common/wb_pkg.sv */
`include "regbank_config.svh"

package wb_pkg;

   // classic single cycle request, held by the master until ack or err
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`WB_ADDR_W-1:0]  adr;  // byte address
      logic [`WB_SEL_W-1:0]   sel;  // lane selects, lane 0 = dat[7:0]
      logic [`WB_DATA_W-1:0]  dat;
   } wb_req_t;

   // slave response, ack and err are one-cycle pulses
   typedef struct packed {
      logic                   ack;
      logic                   err;  // address beyond the bank
      logic [`WB_DATA_W-1:0]  dat;  // zero on err
   } wb_rsp_t;

endpackage

/* common/regbank_pkg.sv */
`include "regbank_config.svh"

package regbank_pkg;

   // write port of the register file
   typedef struct packed {
      logic                   wen;
      logic [`RF_WADDR_W-1:0] waddr;  // word address
      logic [`WB_SEL_W-1:0]   wstrb;  // byte write strobes
      logic [`WB_DATA_W-1:0]  wdata;
   } rf_wreq_t;

   // read port of the register file
   typedef struct packed {
      logic                   ren;
      logic [`RF_WADDR_W-1:0] raddr;  // word address
   } rf_rreq_t;

   // every byte register at once, byte n at [n]
   typedef logic [`REGBANK_N_BYTES-1:0][7:0] regs_t;

endpackage

/* regfile/regfile_2p.sv */
`timescale 1ns/100ps
`include "regbank_config.svh"

module regfile_2p (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  regbank_pkg::rf_wreq_t  wreq_i,
   input  regbank_pkg::rf_rreq_t  rreq_i,
   output logic [`WB_DATA_W-1:0]  rdata_o,
   output regbank_pkg::regs_t     regs_o
);

   localparam int N_WORDS = `REGBANK_N_BYTES / `WB_SEL_W;

   regbank_pkg::regs_t     bank;   // flat byte view of all registers
   logic [`WB_DATA_W-1:0]  rword;  // word selected by raddr

   // byte registers, one per lane of each word
   genvar w;
   genvar j;
   generate
      for (w = 0; w < N_WORDS; w++) begin : g_words
         localparam logic [`RF_WADDR_W-1:0] WORD_ADDR = w;

         logic word_hit;

         assign word_hit = wreq_i.wen && (wreq_i.waddr == WORD_ADDR);

         for (j = 0; j < `WB_SEL_W; j++) begin : g_lanes
            logic [7:0] byte_q;
            logic       byte_we;

            // lane j of the word only when its strobe is set
            assign byte_we = word_hit && wreq_i.wstrb[j];

            always_ff @(posedge clk_i) begin
               if (rst_i) begin
                  byte_q <= '0;
               end else if (byte_we) begin
                  byte_q <= wreq_i.wdata[j*8 +: 8];
               end
            end

            assign bank[w*`WB_SEL_W + j] = byte_q;
         end
      end
   endgenerate

   // word read, lane 0 in the low byte
   assign rword = bank[rreq_i.raddr * `WB_SEL_W +: `WB_SEL_W];
   assign rdata_o = rreq_i.ren ? rword : '0;  // idle port reads zero

   assign regs_o = bank;

   // a write that selects no lane points at a broken request upstream
   a_wen_has_strobe : assert property (
      @(posedge clk_i) disable iff (rst_i)
      wreq_i.wen |-> (wreq_i.wstrb != '0)
   ) else $error("regfile_2p: write enable with empty strobe");

endmodule

/* rtl/wb_decode.sv */
`timescale 1ns/100ps
`include "regbank_config.svh"

module wb_decode (
   input  wb_pkg::wb_req_t        wb_req_i,
   input  logic                   busy_i,
   output regbank_pkg::rf_wreq_t  rf_wreq_o,
   output regbank_pkg::rf_rreq_t  rf_rreq_o,
   output logic                   req_valid_o,
   output logic                   range_err_o
);

   // byte lane bits sit below the word address
   localparam int LANE_W = $clog2(`WB_SEL_W);

   // first byte address past the bank
   localparam logic [`WB_ADDR_W-1:0] BANK_END = `REGBANK_N_BYTES;

   logic                   in_range;
   logic                   take_write;
   logic                   take_read;
   logic [`RF_WADDR_W-1:0] word_addr;

   // a cycle is taken once, busy covers the termination cycle
   assign req_valid_o = wb_req_i.cyc && wb_req_i.stb && !busy_i;

   assign in_range    = (wb_req_i.adr < BANK_END);
   assign range_err_o = !in_range;  // only looked at with req_valid_o

   assign word_addr   = wb_req_i.adr[LANE_W +: `RF_WADDR_W];

   // out-of-range cycles touch neither port
   assign take_write  = req_valid_o && in_range && wb_req_i.we;
   assign take_read   = req_valid_o && in_range && !wb_req_i.we;

   always_comb begin
      rf_wreq_o.wen   = take_write;
      rf_wreq_o.waddr = word_addr;
      rf_wreq_o.wstrb = wb_req_i.sel;  // lane selects map straight to strobes
      rf_wreq_o.wdata = wb_req_i.dat;
   end

   always_comb begin
      rf_rreq_o.ren   = take_read;
      rf_rreq_o.raddr = word_addr;
   end

   // no bus cycle, no write into the bank
   always_comb begin
      if (wb_req_i.cyc === 1'b0) begin
         a_no_write_without_cyc : assert (!rf_wreq_o.wen)
            else $error("wb_decode: write enable outside a bus cycle");
      end
   end

endmodule

/* rtl/read_result.sv */
`timescale 1ns/100ps
`include "regbank_config.svh"

module read_result (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   req_valid_i,
   input  logic                   range_err_i,
   input  logic [`WB_DATA_W-1:0]  rdata_i,
   output logic                   busy_o,
   output wb_pkg::wb_rsp_t        wb_rsp_o
);

   logic                  ack_q;
   logic                  err_q;
   logic [`WB_DATA_W-1:0] dat_q;

   // termination, one clock after the cycle is taken
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_valid_i && !range_err_i;
         err_q <= req_valid_i && range_err_i;
      end
   end

   // read word, zero on err and between cycles
   always_ff @(posedge clk_i) begin
      if (req_valid_i && !range_err_i) begin
         dat_q <= rdata_i;
      end else begin
         dat_q <= '0;
      end
   end

   assign busy_o = ack_q || err_q;  // holds off the held stb for one clock

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.err = err_q;
   assign wb_rsp_o.dat = dat_q;

   a_ack_err_exclusive : assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(ack_q && err_q)
   ) else $error("read_result: ack and err high together");

   // one termination per cycle, never two in a row
   a_single_term : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (ack_q || err_q) |=> !(ack_q || err_q)
   ) else $error("read_result: back-to-back termination");

endmodule

/* rtl/regbank_top.sv */
`timescale 1ns/100ps
`include "regbank_config.svh"

module regbank_top (
   input  logic                clk_i,
   input  logic                rst_i,
   input  wb_pkg::wb_req_t     wb_req_i,
   output wb_pkg::wb_rsp_t     wb_rsp_o,
   output regbank_pkg::regs_t  regs_o
);

   regbank_pkg::rf_wreq_t  rf_wreq;
   regbank_pkg::rf_rreq_t  rf_rreq;
   logic                   req_valid;
   logic                   range_err;
   logic                   busy;       // termination cycle in progress
   logic [`WB_DATA_W-1:0]  rdata;

   // wishbone request into write / read requests
   wb_decode wb_decode_i (
      .wb_req_i    (wb_req_i),
      .busy_i      (busy),
      .rf_wreq_o   (rf_wreq),
      .rf_rreq_o   (rf_rreq),
      .req_valid_o (req_valid),
      .range_err_o (range_err)
   );

   // byte register bank
   regfile_2p regfile_2p_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wreq_i  (rf_wreq),
      .rreq_i  (rf_rreq),
      .rdata_o (rdata),
      .regs_o  (regs_o)
   );

   // read data and ack / err
   read_result read_result_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid),
      .range_err_i (range_err),
      .rdata_i     (rdata),
      .busy_o      (busy),
      .wb_rsp_o    (wb_rsp_o)
   );

endmodule

/* verif/regbank_tb.sv */
`timescale 1ns/100ps

module regbank_tb;

   localparam int N_BYTES = 32;
   localparam int TIMEOUT = 20;  // cycles per wait

   localparam logic [1:0] OP_WR  = 2'd0;
   localparam logic [1:0] OP_RD  = 2'd1;
   localparam logic [1:0] OP_RST = 2'd2;  // reset in the middle of the run

   // one row of the stimulus table
   typedef struct packed {
      logic [1:0]  op;
      logic [7:0]  adr;
      logic [3:0]  sel;
      logic [31:0] dat;
      logic        rnd;      // write data from the lfsr instead of dat
      logic        exp_err;  // cycle must end with err
      logic        hold;     // keep stb high into the next row
   } entry_t;

   logic                clk_i;
   logic                rst_i;
   wb_pkg::wb_req_t     wb_req;
   wb_pkg::wb_rsp_t     wb_rsp;
   regbank_pkg::regs_t  regs_o;

   entry_t      table_q[$];
   logic [7:0]  shadow[0:N_BYTES-1];  // expected bank contents
   logic [31:0] lfsr_state;
   int          errors;
   int          timeouts;
   int          i;
   int          n;
   logic        stopped;

   regbank_top regbank_top_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp),
      .regs_o   (regs_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int b = 0; b < 32; b++) begin
         lfsr_state = lfsr_step(lfsr_state);  // one step per bit
         w = {w[30:0], lfsr_state[0]};
      end
      return w;
   endfunction

   task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // lane j goes to byte word*4 + j, low address bits ignored
   task automatic shadow_write(input logic [7:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat);
      int base;
      base = {adr[7:2], 2'b00};
      for (int j = 0; j < 4; j++) begin
         if (sel[j]) shadow[base + j] = dat[j*8 +: 8];
      end
   endtask

   function automatic logic [31:0] shadow_word(input logic [7:0] adr);
      int base;
      base = {adr[7:2], 2'b00};
      return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
   endfunction

   function automatic logic [255:0] shadow_flat();
      logic [255:0] flat;
      for (int k = 0; k < N_BYTES; k++) flat[k*8 +: 8] = shadow[k];
      return flat;
   endfunction

   task automatic add_entry(input logic [1:0] op, input logic [7:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, input logic rnd, input logic exp_err,
                            input logic hold);
      table_q.push_back('{op, adr, sel, dat, rnd, exp_err, hold});
   endtask

   task automatic build_table();
      for (int w = 0; w < 8; w++) add_entry(OP_RD, 8'(w * 4), 4'hf, 0, 0, 0, 0);
      // full words, lfsr data
      for (int w = 0; w < 8; w++) add_entry(OP_WR, 8'(w * 4), 4'hf, 0, 1, 0, 0);
      for (int w = 0; w < 8; w++) add_entry(OP_RD, 8'(w * 4), 4'hf, 0, 0, 0, 0);
      // single lanes and mixed selects
      add_entry(OP_WR, 8'd0,  4'b0001, 32'h0000_00a5, 0, 0, 0);
      add_entry(OP_WR, 8'd5,  4'b0010, 32'hdead_3cef, 0, 0, 0);  // word 1, offset ignored
      add_entry(OP_WR, 8'd8,  4'b1000, 32'h7e11_2233, 0, 0, 0);
      add_entry(OP_WR, 8'd12, 4'b0101, 32'h4400_5566, 0, 0, 0);
      add_entry(OP_WR, 8'd16, 4'b1010, 32'h9900_8800, 0, 0, 0);
      add_entry(OP_WR, 8'd28, 4'b0110, 32'hff12_34ff, 0, 0, 0);
      add_entry(OP_WR, 8'd24, 4'b0100, 0, 1, 0, 0);
      for (int w = 0; w < 8; w++) add_entry(OP_RD, 8'(w * 4), 4'hf, 0, 0, 0, 0);
      // beyond the bank
      add_entry(OP_WR, 8'd32,  4'hf, 32'hffff_ffff, 0, 1, 0);
      add_entry(OP_RD, 8'd32,  4'hf, 0, 0, 1, 0);
      add_entry(OP_WR, 8'd255, 4'b0011, 32'h1234_5678, 0, 1, 0);
      add_entry(OP_RD, 8'd64,  4'hf, 0, 0, 1, 0);
      add_entry(OP_RD, 8'd36,  4'hf, 0, 0, 1, 0);
      add_entry(OP_RD, 8'd0,   4'hf, 0, 0, 0, 0);
      // stb held across rows
      add_entry(OP_WR, 8'd20, 4'hf,    32'h1234_5678, 0, 0, 1);
      add_entry(OP_RD, 8'd20, 4'hf,    0, 0, 0, 1);
      add_entry(OP_WR, 8'd20, 4'b0001, 32'h0000_00ff, 0, 0, 1);
      add_entry(OP_RD, 8'd40, 4'hf,    0, 0, 1, 1);
      add_entry(OP_WR, 8'd4,  4'b1100, 0, 1, 0, 1);
      add_entry(OP_RD, 8'd20, 4'hf,    0, 0, 0, 1);
      add_entry(OP_RD, 8'd4,  4'hf,    0, 0, 0, 0);
      add_entry(OP_RST, 8'd0, 4'h0, 0, 0, 0, 0);
      for (int w = 0; w < 8; w++) add_entry(OP_RD, 8'(w * 4), 4'hf, 0, 0, 0, 0);
   endtask

   // called just after a rising edge, returns at the same point of a later cycle
   task automatic run_entry(input entry_t e, input int idx);
      logic [31:0] wdat;
      int          waits;
      logic        done;
      wdat = e.rnd ? rand_word() : e.dat;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = (e.op == OP_WR);
      wb_req.adr = e.adr;
      wb_req.sel = e.sel;
      wb_req.dat = wdat;
      waits = 0;
      done  = 1'b0;
      while (!done && waits < TIMEOUT) begin
         @(negedge clk_i);
         waits++;
         done = wb_rsp.ack || wb_rsp.err;
      end
      if (!done) begin
         timeouts++;
         stopped = 1'b1;
         $display("entry %0d got neither ack nor err within %0d cycles", idx, TIMEOUT);
         wb_req = '0;
      end else begin
         check("latency", waits, 2);  // taken at the next edge, terminated one clock later
         check("wb_rsp.ack", wb_rsp.ack, !e.exp_err);
         check("wb_rsp.err", wb_rsp.err, e.exp_err);
         if (e.op == OP_WR && !e.exp_err) shadow_write(e.adr, e.sel, wdat);
         if (e.op == OP_RD || e.exp_err) begin
            check("wb_rsp.dat", wb_rsp.dat, e.exp_err ? 32'h0 : shadow_word(e.adr));
         end
         check("regs_o", regs_o, shadow_flat());
         @(posedge clk_i);
         #0.5;
         if (!e.hold) begin
            wb_req = '0;
            @(negedge clk_i);
            check("wb_rsp.ack", wb_rsp.ack, 1'b0);  // no second termination
            check("wb_rsp.err", wb_rsp.err, 1'b0);
            @(posedge clk_i);
            #0.5;
         end
      end
   endtask

   task automatic apply_reset();
      rst_i = 1'b1;
      repeat (4) @(posedge clk_i);
      #0.5;
      rst_i = 1'b0;
      for (int k = 0; k < N_BYTES; k++) shadow[k] = 8'h00;
      @(negedge clk_i);
      check("regs_o", regs_o, '0);
      @(posedge clk_i);
      #0.5;
   endtask

   initial begin
      errors     = 0;
      timeouts   = 0;
      stopped    = 1'b0;
      lfsr_state = 32'h027d_9ae6;
      rst_i      = 1'b1;
      wb_req     = '0;
      for (n = 0; n < N_BYTES; n++) shadow[n] = 8'h00;
      build_table();
      repeat (16) @(posedge clk_i);
      #0.5;
      rst_i = 1'b0;
      @(negedge clk_i);
      check("regs_o", regs_o, '0);
      check("wb_rsp.ack", wb_rsp.ack, 1'b0);
      check("wb_rsp.err", wb_rsp.err, 1'b0);
      @(posedge clk_i);
      #0.5;
      for (i = 0; i < table_q.size() && !stopped; i++) begin
         if (table_q[i].op == OP_RST) apply_reset();
         else run_entry(table_q[i], i);
      end
      $display("done: %0d entries, %0d errors, %0d timeouts", i, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+common
common/wb_pkg.sv
common/regbank_pkg.sv
regfile/regfile_2p.sv
rtl/wb_decode.sv
rtl/read_result.sv
rtl/regbank_top.sv
verif/regbank_tb.sv

/* Makefile */
# Verilator build and run of the register bank testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module regbank_tb \
		-f all.f --Mdir obj_dir -o regbank_sim
	./obj_dir/regbank_sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
